/* Bender.yml */
package:
  name: mem_port

sources:
  - mem_port_pkg.sv
  - reset_stretch.sv
  - cache_warmup.sv
  - port_arbiter_ctrl.sv
  - read_mux.sv
  - mem_port_top.sv
  - target: test
    files:
      - tb_mem_port.sv

/* cache_warmup.sv */
module cache_warmup (
    input  logic Clk,
    input  logic core_reset_i,
    input  logic unc_last_i,
    output logic refill_open_o
);

    logic [mem_port_pkg::WARMUP_W-1:0] left_q;

    // Uncached reads still to complete before refills are let through.
    always_ff @(posedge Clk) begin
        if (core_reset_i) begin
            left_q <= mem_port_pkg::WARMUP_INIT;
        end else if (unc_last_i && (left_q != '0)) begin
            left_q <= left_q - 1'b1;
        end
    end

    assign refill_open_o = (left_q == '0);

    // ********************
    // Checks.
    // ********************

    // Once open, refills stay open until the next reset.
    a_open_sticky: assert property (
        @(posedge Clk) disable iff (core_reset_i)
        refill_open_o |=> refill_open_o
    ) else $error("refill gate closed again outside reset");

endmodule

/* mem_port.f */
mem_port_pkg.sv
reset_stretch.sv
cache_warmup.sv
port_arbiter_ctrl.sv
read_mux.sv
mem_port_top.sv
tb_mem_port.sv

/* mem_port_pkg.sv */
package mem_port_pkg;

    // ********************
    // Port geometry.
    // ********************
    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int LEN_W         = 4;
    localparam int LINE_BEATS    = 8;
    localparam int LINE_OFFSET_W = 5;
    localparam int BEAT_SIZE     = 2;

    localparam logic [LEN_W-1:0] REFILL_LEN = LEN_W'(LINE_BEATS - 1);

    // ********************
    // Start-up timing.
    // ********************
    localparam int STRETCH_CYCLES = 128;
    localparam int STRETCH_W      = $clog2(STRETCH_CYCLES);
    localparam int WARMUP_READS   = 3;
    localparam int WARMUP_W       = $clog2(WARMUP_READS + 1);

    localparam logic [STRETCH_W-1:0] STRETCH_LAST = STRETCH_W'(STRETCH_CYCLES - 1);
    localparam logic [WARMUP_W-1:0]  WARMUP_INIT  = WARMUP_W'(WARMUP_READS);

    // Read sources, listed in priority order. Also the AR id.
    typedef enum logic [1:0] {
        SRC_DATA = 2'd0,
        SRC_INST = 2'd1,
        SRC_UNC  = 2'd2
    } src_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADDR = 2'd1,
        ST_DATA = 2'd2
    } arb_state_e;

endpackage

/* mem_port_top.sv */
module mem_port_top (
    input  logic                              Clk,
    input  logic                              Myreset,

    input  logic                              data_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]   data_addr_i,
    output logic                              data_rvalid_o,
    output logic                              data_done_o,
    input  logic                              inst_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]   inst_addr_i,
    output logic                              inst_rvalid_o,
    output logic                              inst_done_o,
    input  logic                              unc_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]   unc_addr_i,
    output logic                              unc_rvalid_o,
    output logic                              unc_done_o,
    output logic [mem_port_pkg::DATA_W-1:0]   rdata_o,

    output logic                              ar_valid_o,
    output logic [mem_port_pkg::ADDR_W-1:0]   ar_addr_o,
    output logic [mem_port_pkg::LEN_W-1:0]    ar_len_o,
    output mem_port_pkg::src_e                ar_id_o,
    input  logic                              ar_ready_i,
    input  logic                              r_valid_i,
    input  logic [mem_port_pkg::DATA_W-1:0]   r_data_i,
    input  logic                              r_last_i,
    output logic                              r_ready_o
);

    logic               core_reset;
    logic               refill_open;
    logic               unc_last;
    mem_port_pkg::src_e grant;
    logic               grant_load;
    logic               addr_phase;
    logic               data_phase;
    logic               ar_done;
    logic               beat;
    logic               last_beat;

    reset_stretch u_reset_stretch (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .core_reset_o (core_reset)
    );

    cache_warmup u_cache_warmup (
        .Clk           (Clk),
        .core_reset_i  (core_reset),
        .unc_last_i    (unc_last),
        .refill_open_o (refill_open)
    );

    port_arbiter_ctrl u_ctrl (
        .Clk           (Clk),
        .core_reset_i  (core_reset),
        .refill_open_i (refill_open),
        .data_req_i    (data_req_i),
        .inst_req_i    (inst_req_i),
        .unc_req_i     (unc_req_i),
        .ar_done_i     (ar_done),
        .last_beat_i   (last_beat),
        .grant_o       (grant),
        .grant_load_o  (grant_load),
        .addr_phase_o  (addr_phase),
        .data_phase_o  (data_phase),
        .data_done_o   (data_done_o),
        .inst_done_o   (inst_done_o),
        .unc_done_o    (unc_done_o),
        .unc_last_o    (unc_last)
    );

    read_mux u_read_mux (
        .Clk           (Clk),
        .core_reset_i  (core_reset),
        .grant_i       (grant),
        .grant_load_i  (grant_load),
        .addr_phase_i  (addr_phase),
        .data_phase_i  (data_phase),
        .data_addr_i   (data_addr_i),
        .inst_addr_i   (inst_addr_i),
        .unc_addr_i    (unc_addr_i),
        .ar_ready_i    (ar_ready_i),
        .r_valid_i     (r_valid_i),
        .r_data_i      (r_data_i),
        .r_last_i      (r_last_i),
        .ar_valid_o    (ar_valid_o),
        .ar_addr_o     (ar_addr_o),
        .ar_len_o      (ar_len_o),
        .ar_id_o       (ar_id_o),
        .r_ready_o     (r_ready_o),
        .rdata_o       (rdata_o),
        .data_rvalid_o (data_rvalid_o),
        .inst_rvalid_o (inst_rvalid_o),
        .unc_rvalid_o  (unc_rvalid_o),
        .ar_done_o     (ar_done),
        .beat_o        (beat),
        .last_beat_o   (last_beat)
    );

endmodule

/* port_arbiter_ctrl.sv */
module port_arbiter_ctrl (
    input  logic               Clk,
    input  logic               core_reset_i,
    input  logic               refill_open_i,
    input  logic               data_req_i,
    input  logic               inst_req_i,
    input  logic               unc_req_i,
    input  logic               ar_done_i,
    input  logic               last_beat_i,
    output mem_port_pkg::src_e grant_o,
    output logic               grant_load_o,
    output logic               addr_phase_o,
    output logic               data_phase_o,
    output logic               data_done_o,
    output logic               inst_done_o,
    output logic               unc_done_o,
    output logic               unc_last_o
);

    mem_port_pkg::arb_state_e state_q;
    mem_port_pkg::arb_state_e state_d;
    mem_port_pkg::src_e       grant_q;
    mem_port_pkg::src_e       pick;
    logic                     data_ok;
    logic                     inst_ok;
    logic                     any_req;
    logic                     finish;

    // ********************
    // Fixed priority.
    // ********************

    // Refills wait for the warm-up gate.
    assign data_ok = data_req_i & refill_open_i;
    assign inst_ok = inst_req_i & refill_open_i;
    assign any_req = data_ok | inst_ok | unc_req_i;

    always_comb begin
        if (data_ok) begin
            pick = mem_port_pkg::SRC_DATA;
        end else if (inst_ok) begin
            pick = mem_port_pkg::SRC_INST;
        end else begin
            pick = mem_port_pkg::SRC_UNC;
        end
    end

    assign grant_load_o = (state_q == mem_port_pkg::ST_IDLE) && any_req;
    assign grant_o      = (state_q == mem_port_pkg::ST_IDLE) ? pick : grant_q;

    // ********************
    // Phase sequencing.
    // ********************
    assign addr_phase_o = (state_q == mem_port_pkg::ST_ADDR);
    assign data_phase_o = (state_q == mem_port_pkg::ST_DATA);
    assign finish       = data_phase_o && last_beat_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_port_pkg::ST_IDLE: begin
                if (any_req) begin
                    state_d = mem_port_pkg::ST_ADDR;
                end
            end
            mem_port_pkg::ST_ADDR: begin
                if (ar_done_i) begin
                    state_d = mem_port_pkg::ST_DATA;
                end
            end
            mem_port_pkg::ST_DATA: begin
                if (last_beat_i) begin
                    state_d = mem_port_pkg::ST_IDLE;
                end
            end
            default: state_d = mem_port_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (core_reset_i) begin
            state_q <= mem_port_pkg::ST_IDLE;
            grant_q <= mem_port_pkg::SRC_DATA;
        end else begin
            state_q <= state_d;
            if (grant_load_o) begin
                grant_q <= pick;
            end
        end
    end

    // Done goes to the owner of the finished burst.
    assign data_done_o = finish && (grant_q == mem_port_pkg::SRC_DATA);
    assign inst_done_o = finish && (grant_q == mem_port_pkg::SRC_INST);
    assign unc_done_o  = finish && (grant_q == mem_port_pkg::SRC_UNC);
    assign unc_last_o  = unc_done_o;

    // ********************
    // Checks.
    // ********************
    a_grant_hold: assert property (
        @(posedge Clk) disable iff (core_reset_i)
        (state_q != mem_port_pkg::ST_IDLE) |-> $stable(grant_o)
    ) else $error("grant changed during a transaction");

    // A done closes the data phase and the port goes idle next.
    a_done_in_data: assert property (
        @(posedge Clk) disable iff (core_reset_i)
        (data_done_o || inst_done_o || unc_done_o) |->
            (state_q == mem_port_pkg::ST_DATA) ##1 (state_q == mem_port_pkg::ST_IDLE)
    ) else $error("done pulse outside the data phase");

endmodule

/* read_mux.sv */
module read_mux (
    input  logic                              Clk,
    input  logic                              core_reset_i,
    input  mem_port_pkg::src_e                grant_i,
    input  logic                              grant_load_i,
    input  logic                              addr_phase_i,
    input  logic                              data_phase_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]   data_addr_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]   inst_addr_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]   unc_addr_i,
    input  logic                              ar_ready_i,
    input  logic                              r_valid_i,
    input  logic [mem_port_pkg::DATA_W-1:0]   r_data_i,
    input  logic                              r_last_i,
    output logic                              ar_valid_o,
    output logic [mem_port_pkg::ADDR_W-1:0]   ar_addr_o,
    output logic [mem_port_pkg::LEN_W-1:0]    ar_len_o,
    output mem_port_pkg::src_e                ar_id_o,
    output logic                              r_ready_o,
    output logic [mem_port_pkg::DATA_W-1:0]   rdata_o,
    output logic                              data_rvalid_o,
    output logic                              inst_rvalid_o,
    output logic                              unc_rvalid_o,
    output logic                              ar_done_o,
    output logic                              beat_o,
    output logic                              last_beat_o
);

    logic [mem_port_pkg::ADDR_W-1:0] sel_addr;
    logic [mem_port_pkg::ADDR_W-1:0] addr_q;
    logic [mem_port_pkg::LEN_W-1:0]  len_q;
    mem_port_pkg::src_e              id_q;
    logic                            refill;

    // ********************
    // Request capture.
    // ********************
    always_comb begin
        case (grant_i)
            mem_port_pkg::SRC_DATA: sel_addr = data_addr_i;
            mem_port_pkg::SRC_INST: sel_addr = inst_addr_i;
            default:                sel_addr = unc_addr_i;
        endcase
    end

    assign refill = (grant_i != mem_port_pkg::SRC_UNC);

    // Refills fetch the whole line from its start. A single read is only
    // word aligned, the size code doubling as the offset width.
    always_ff @(posedge Clk) begin
        if (grant_load_i) begin
            id_q <= grant_i;
            if (refill) begin
                addr_q <= {sel_addr[mem_port_pkg::ADDR_W-1:mem_port_pkg::LINE_OFFSET_W],
                           {mem_port_pkg::LINE_OFFSET_W{1'b0}}};
                len_q  <= mem_port_pkg::REFILL_LEN;
            end else begin
                addr_q <= {sel_addr[mem_port_pkg::ADDR_W-1:mem_port_pkg::BEAT_SIZE],
                           {mem_port_pkg::BEAT_SIZE{1'b0}}};
                len_q  <= '0;
            end
        end
    end

    // ********************
    // AR and R channels.
    // ********************
    assign ar_valid_o = addr_phase_i;
    assign ar_addr_o  = addr_q;
    assign ar_len_o   = len_q;
    assign ar_id_o    = id_q;
    assign ar_done_o  = addr_phase_i & ar_ready_i;

    assign r_ready_o   = data_phase_i;
    assign beat_o      = r_valid_i & data_phase_i;
    assign last_beat_o = beat_o & r_last_i;
    assign rdata_o     = r_data_i;

    // Beats go only to the source that owns the burst.
    assign data_rvalid_o = beat_o && (id_q == mem_port_pkg::SRC_DATA);
    assign inst_rvalid_o = beat_o && (id_q == mem_port_pkg::SRC_INST);
    assign unc_rvalid_o  = beat_o && (id_q == mem_port_pkg::SRC_UNC);

    // ********************
    // Checks.
    // ********************
    a_ar_hold: assert property (
        @(posedge Clk) disable iff (core_reset_i)
        (ar_valid_o && !ar_ready_i) |=>
            (ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o) && $stable(ar_id_o))
    ) else $error("AR request changed while stalled");

endmodule

/* reset_stretch.sv */
module reset_stretch (
    input  logic Clk,
    input  logic Myreset,
    output logic core_reset_o
);

    logic [mem_port_pkg::STRETCH_W-1:0] cnt_q;
    logic                               hold_q;

    // The core stays in reset while the counter runs up after the external
    // reset has gone low.
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            hold_q <= 1'b1;
            cnt_q  <= '0;
        end else if (hold_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == mem_port_pkg::STRETCH_LAST) begin
                hold_q <= 1'b0;
            end
        end
    end

    assign core_reset_o = hold_q;

endmodule

/* tb_mem_port.sv */
module tb_mem_port;

    localparam int N_DATA  = 4;
    localparam int N_INST  = 3;
    localparam int N_UNC   = 5;
    localparam int OFF_W   = mem_port_pkg::LINE_OFFSET_W;
    // Generous bound on one read with random stalls.
    localparam int TXN_MAX = 8 * (mem_port_pkg::LINE_BEATS + 3);
    localparam int TIMEOUT = 16 + mem_port_pkg::STRETCH_CYCLES
                           + (N_DATA + N_INST + N_UNC) * TXN_MAX;

    logic                              Clk;
    logic                              Myreset;
    logic                              data_req_i;
    logic [mem_port_pkg::ADDR_W-1:0]   data_addr_i;
    logic                              data_rvalid_o;
    logic                              data_done_o;
    logic                              inst_req_i;
    logic [mem_port_pkg::ADDR_W-1:0]   inst_addr_i;
    logic                              inst_rvalid_o;
    logic                              inst_done_o;
    logic                              unc_req_i;
    logic [mem_port_pkg::ADDR_W-1:0]   unc_addr_i;
    logic                              unc_rvalid_o;
    logic                              unc_done_o;
    logic [mem_port_pkg::DATA_W-1:0]   rdata_o;
    logic                              ar_valid_o;
    logic [mem_port_pkg::ADDR_W-1:0]   ar_addr_o;
    logic [mem_port_pkg::LEN_W-1:0]    ar_len_o;
    mem_port_pkg::src_e                ar_id_o;
    logic                              ar_ready_i;
    logic                              r_valid_i;
    logic [mem_port_pkg::DATA_W-1:0]   r_data_i;
    logic                              r_last_i;
    logic                              r_ready_o;

    int                                data_left;
    int                                inst_left;
    int                                unc_left;
    int                                low_cycles;
    int                                ar_count;
    int                                beat_idx;
    logic [2:0]                        fin;
    logic                              burst_on;
    mem_port_pkg::src_e                burst_id;
    logic [mem_port_pkg::ADDR_W-1:0]   burst_addr;
    logic [mem_port_pkg::LEN_W-1:0]    burst_len;
    logic                              ar_hs;
    logic                              r_hs;
    logic [mem_port_pkg::ADDR_W-1:0]   req_addr;

    mem_port_top dut_i (.*);

    always #2 Clk = ~Clk;

    assign ar_hs = ar_valid_o && ar_ready_i;
    assign r_hs  = r_valid_i && r_ready_o;

    // Address presented by the source that the AR id names.
    assign req_addr = (ar_id_o == mem_port_pkg::SRC_DATA) ? data_addr_i :
                      (ar_id_o == mem_port_pkg::SRC_INST) ? inst_addr_i : unc_addr_i;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic flag_error(input string what);
        $display("ERR %0t: %s", $time, what);
        abort_run();
    endtask

    initial begin
        void'($urandom(59));
        Clk         = 1'b0;
        Myreset     = 1'b1;
        data_left   = N_DATA;
        inst_left   = N_INST;
        unc_left    = N_UNC;
        data_req_i  = 1'b0;
        inst_req_i  = 1'b0;
        unc_req_i   = 1'b0;
        data_addr_i = $urandom;
        inst_addr_i = $urandom;
        unc_addr_i  = $urandom;
        ar_ready_i  = 1'b0;
        r_valid_i   = 1'b0;
        r_data_i    = '0;
        r_last_i    = 1'b0;
        repeat (16) @(posedge Clk);
        #1;
        Myreset = 1'b0;
        wait ((data_left == 0) && (inst_left == 0) && (unc_left == 0));
        repeat (4) @(posedge Clk);
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge Clk);
        $display("Timeout: the scripted reads did not finish within %0d cycles", TIMEOUT);
        abort_run();
    end

    // ********************
    // Sources and slave.
    // ********************

    // A source moves to a fresh address after each done and drops its request when idle.
    always @(posedge Clk) begin
        fin = {data_done_o, inst_done_o, unc_done_o};
        #1;
        if (fin[2]) begin
            data_left   = data_left - 1;
            data_addr_i = $urandom;
        end
        if (fin[1]) begin
            inst_left   = inst_left - 1;
            inst_addr_i = $urandom;
        end
        if (fin[0]) begin
            unc_left   = unc_left - 1;
            unc_addr_i = $urandom;
        end
        data_req_i = (data_left != 0);
        inst_req_i = (inst_left != 0);
        unc_req_i  = (unc_left != 0);
    end

    // Read slave: len plus one beats, each carrying its own byte address.
    always @(posedge Clk) begin
        if (Myreset) begin
            low_cycles = 0;
            ar_count   = 0;
            beat_idx   = 0;
            burst_on   = 1'b0;
            burst_id   = mem_port_pkg::SRC_DATA;
            burst_addr = '0;
            burst_len  = '0;
        end else begin
            if (low_cycles <= mem_port_pkg::STRETCH_CYCLES) begin
                low_cycles = low_cycles + 1;
            end
            if (r_hs && r_last_i) begin
                burst_on = 1'b0;
            end else if (r_hs) begin
                beat_idx = beat_idx + 1;
            end
            if (ar_hs) begin
                burst_on   = 1'b1;
                burst_id   = ar_id_o;
                burst_addr = ar_addr_o;
                burst_len  = ar_len_o;
                beat_idx   = 0;
                ar_count   = ar_count + 1;
            end
        end
        #1;
        ar_ready_i = (($urandom % 3) != 0);
        r_valid_i  = burst_on && (($urandom % 3) != 0);
        r_data_i   = burst_addr + 4 * beat_idx;
        r_last_i   = burst_on && (beat_idx == burst_len);
    end

    // ********************
    // Checks.
    // ********************
    a_stretch: assert property (@(posedge Clk) disable iff (Myreset)
        (low_cycles <= mem_port_pkg::STRETCH_CYCLES) |->
            !(ar_valid_o || r_ready_o || data_rvalid_o || inst_rvalid_o || unc_rvalid_o
              || data_done_o || inst_done_o || unc_done_o)
    ) else flag_error("port active during the stretched reset");

    a_warmup: assert property (@(posedge Clk) disable iff (Myreset)
        (ar_hs && (ar_count < mem_port_pkg::WARMUP_READS)) |->
            (ar_id_o == mem_port_pkg::SRC_UNC) && (ar_len_o == '0)
    ) else flag_error("refill issued before warm-up completed");

    // Data beats instruction, which beats uncached.
    a_priority: assert property (@(posedge Clk) disable iff (Myreset)
        (ar_hs && (ar_count >= mem_port_pkg::WARMUP_READS)) |->
            ar_id_o == (data_req_i ? mem_port_pkg::SRC_DATA :
                        (inst_req_i ? mem_port_pkg::SRC_INST : mem_port_pkg::SRC_UNC))
    ) else flag_error("wrong source granted");

    a_refill_shape: assert property (@(posedge Clk) disable iff (Myreset)
        (ar_hs && (ar_id_o != mem_port_pkg::SRC_UNC)) |->
            (ar_addr_o[OFF_W-1:0] == '0) && (ar_len_o == mem_port_pkg::LINE_BEATS - 1)
    ) else flag_error("refill address or length malformed");

    // Refills keep the line part of the address, single reads the word part.
    a_ar_addr: assert property (@(posedge Clk) disable iff (Myreset)
        ar_hs |->
            (ar_addr_o[mem_port_pkg::ADDR_W-1:OFF_W] == req_addr[mem_port_pkg::ADDR_W-1:OFF_W])
            && ((ar_id_o != mem_port_pkg::SRC_UNC)
                || (ar_addr_o[OFF_W-1:2] == req_addr[OFF_W-1:2]))
    ) else flag_error("AR address does not match the requesting source");

    a_route: assert property (@(posedge Clk) disable iff (Myreset)
        (data_rvalid_o == (r_hs && (burst_id == mem_port_pkg::SRC_DATA)))
        && (inst_rvalid_o == (r_hs && (burst_id == mem_port_pkg::SRC_INST)))
        && (unc_rvalid_o == (r_hs && (burst_id == mem_port_pkg::SRC_UNC)))
    ) else flag_error("beat valid routed to the wrong source");

    a_rdata: assert property (@(posedge Clk) disable iff (Myreset)
        r_hs |-> (rdata_o == burst_addr + 4 * beat_idx)
    ) else flag_error("read data differs from slave beat");

    a_done: assert property (@(posedge Clk) disable iff (Myreset)
        (data_done_o == (r_hs && r_last_i && (burst_id == mem_port_pkg::SRC_DATA)))
        && (inst_done_o == (r_hs && r_last_i && (burst_id == mem_port_pkg::SRC_INST)))
        && (unc_done_o == (r_hs && r_last_i && (burst_id == mem_port_pkg::SRC_UNC)))
    ) else flag_error("done pulse not on the owner's last beat");

    a_beat_count: assert property (@(posedge Clk) disable iff (Myreset)
        (r_hs && r_last_i) |-> (beat_idx == ((burst_id == mem_port_pkg::SRC_UNC) ?
                                             0 : mem_port_pkg::LINE_BEATS - 1))
    ) else flag_error("burst ended after the wrong number of beats");

    a_ar_hold: assert property (@(posedge Clk) disable iff (Myreset)
        (ar_valid_o && !ar_ready_i) |=>
            (ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o) && $stable(ar_id_o))
    ) else flag_error("AR request changed while stalled");

    a_r_ready: assert property (@(posedge Clk) disable iff (Myreset)
        r_ready_o == burst_on
    ) else flag_error("r_ready outside the data phase");

endmodule
